//--- design/core_cfg.svh
//******************************
// Core configuration
// Word, field and register file sizes
//******************************
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_WORD_W    20 // Register and full-word width
`define CORE_HALF_W    10 // Half-word width
`define CORE_OP_W      6  // Opcode width
`define CORE_REG_AW    3  // Register address width
`define CORE_NUM_REGS  8  // General registers
`define CORE_MODE_BIT  1  // Half-word mode bit
`define CORE_SRC1_LSB  11 // Source 1 field
`define CORE_SRC2_LSB  8  // Source 2 field
`define CORE_DST1_LSB  5  // Destination 1 field
`define CORE_DST2_LSB  2  // Destination 2 field

`endif

//--- design/core_pkg.sv
//******************************
// Core package
// Data, opcode and phase types
//******************************
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_WORD_W-1:0] word_t;    // Data word
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t; // Register index

    localparam word_t HALF_MASK = word_t'({`CORE_HALF_W{1'b1}}); // Low half-word bits

    typedef enum logic [`CORE_OP_W-1:0] {
        OP_TRAP  = 6'd0,
        OP_NOP   = 6'd1,
        OP_NOT   = 6'd8,
        OP_AND   = 6'd9,
        OP_OR    = 6'd10,
        OP_XOR   = 6'd11,
        OP_SHFTR = 6'd12,
        OP_SHFTL = 6'd13,
        OP_ROTR  = 6'd14,
        OP_ROTL  = 6'd15,
        OP_SWAP  = 6'd16,
        OP_INC   = 6'd17,
        OP_DEC   = 6'd18,
        OP_ADD   = 6'd19,
        OP_SUB   = 6'd21,
        OP_EQ    = 6'd23,
        OP_GT    = 6'd24,
        OP_LT    = 6'd25
    } opcode_e;

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_DECODE,
        PH_EXECUTE,
        PH_WRITE_BACK
    } phase_e;

endpackage

`default_nettype wire

//--- design/phase_sequencer.sv
//******************************
// Phase sequencer
// Rotates the four phase enables and halts on TRAP
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module phase_sequencer import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  opcode_e op,                // Decoded opcode of current instruction
    output logic    fetch_enable,
    output logic    decode_enable,
    output logic    execute_enable,
    output logic    write_back_enable,
    output logic    trap_mode          // Sticky until reset
);

    phase_e phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_FETCH;
            trap_mode <= 1'b0;
        end else if (!trap_mode) begin
            case (phase)
                PH_FETCH:      phase <= PH_DECODE;
                PH_DECODE:     phase <= PH_EXECUTE;
                PH_EXECUTE:    phase <= PH_WRITE_BACK;
                PH_WRITE_BACK: phase <= PH_FETCH;
                default:       phase <= PH_FETCH;
            endcase
            if (phase == PH_DECODE && op == OP_TRAP) begin
                trap_mode <= 1'b1; // Stop the core for good
            end
        end
    end

    // One level per phase, all dropped once trapped
    assign fetch_enable      = (phase == PH_FETCH) && !trap_mode;
    assign decode_enable     = (phase == PH_DECODE) && !trap_mode;
    assign execute_enable    = (phase == PH_EXECUTE) && !trap_mode;
    assign write_back_enable = (phase == PH_WRITE_BACK) && !trap_mode;

    a_enables_onehot0: assert property (@(posedge clk) disable iff (reset)
        $onehot0({fetch_enable, decode_enable, execute_enable, write_back_enable}))
        else $error("More than one phase enable high");

    // Trap decision relies on op being held between fetches
    a_op_held: assert property (@(posedge clk) disable iff (reset)
        !$past(fetch_enable) |-> $stable(op))
        else $error("Opcode changed outside the fetch phase");

endmodule

`default_nettype wire

//--- design/instr_decode.sv
//******************************
// Instruction decode
// Latches and splits the instruction, captures operands
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module instr_decode import core_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_enable,
    input  logic                    decode_enable,
    input  logic [`CORE_WORD_W-1:0] instruction,
    input  word_t                   rd_a_data,   // Source 1 value from reg file
    input  word_t                   rd_b_data,   // Source 2 value from reg file
    output opcode_e                 op,
    output reg_addr_t               src1,
    output reg_addr_t               src2,
    output reg_addr_t               dst1,
    output reg_addr_t               dst2,
    output logic                    half_mode,
    output word_t                   operand_a,
    output word_t                   operand_b
);

    // Unsupported codes fall back to NOP
    function automatic opcode_e decode_op(input logic [`CORE_OP_W-1:0] raw);
        opcode_e op_v;
        op_v = opcode_e'(raw);
        case (op_v)
            OP_TRAP, OP_NOP, OP_NOT, OP_AND, OP_OR, OP_XOR,
            OP_SHFTR, OP_SHFTL, OP_ROTR, OP_ROTL, OP_SWAP,
            OP_INC, OP_DEC, OP_ADD, OP_SUB, OP_EQ, OP_GT, OP_LT: decode_op = op_v;
            default: decode_op = OP_NOP;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            op        <= OP_NOP;
            half_mode <= 1'b0;
        end else if (fetch_enable) begin
            op        <= decode_op(instruction[`CORE_WORD_W-1 -: `CORE_OP_W]);
            half_mode <= instruction[`CORE_MODE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_enable) begin
            src1 <= instruction[`CORE_SRC1_LSB +: `CORE_REG_AW];
            src2 <= instruction[`CORE_SRC2_LSB +: `CORE_REG_AW];
            dst1 <= instruction[`CORE_DST1_LSB +: `CORE_REG_AW];
            dst2 <= instruction[`CORE_DST2_LSB +: `CORE_REG_AW];
        end
        if (decode_enable) begin
            operand_a <= half_mode ? (rd_a_data & HALF_MASK) : rd_a_data; // Cut to low half
            operand_b <= half_mode ? (rd_b_data & HALF_MASK) : rd_b_data;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
//******************************
// Register file
// Eight general registers with load and write-back ports
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_a_addr,
    input  reg_addr_t rd_b_addr,
    input  reg_addr_t rd_addr,   // External read port
    output word_t     rd_a_data,
    output word_t     rd_b_data,
    output word_t     rd_data,
    input  logic      wr1_en,
    input  logic      wr2_en,
    input  reg_addr_t wr1_addr,
    input  reg_addr_t wr2_addr,
    input  word_t     wr1_data,
    input  word_t     wr2_data,
    input  logic      load_en,   // External load port
    input  reg_addr_t load_addr,
    input  word_t     load_data
);

    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr1_en) regs[wr1_addr] <= wr1_data;
            if (wr2_en) regs[wr2_addr] <= wr2_data; // Port 2 wins on same address
            if (load_en && !wr1_en && !wr2_en) begin
                regs[load_addr] <= load_data; // Only when write-back is idle
            end
        end
    end

    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];
    assign rd_data   = regs[rd_addr];

    a_no_load_collision: assert property (@(posedge clk) disable iff (reset)
        !(load_en && (wr1_en || wr2_en)))
        else $error("External load during write-back write");

endmodule

`default_nettype wire

//--- design/alu_execute.sv
//******************************
// Execute stage
// Computes results and flag updates in full or half width
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module alu_execute import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    execute_enable,
    input  opcode_e op,
    input  logic    half_mode,
    input  word_t   operand_a,
    input  word_t   operand_b,
    output word_t   result1,
    output word_t   result2,
    output logic    wr1,        // Write dst1
    output logic    wr2,        // Write dst2
    output logic    zero_val,
    output logic    sign_val,
    output logic    carry_val,
    output logic    zero_upd,   // Flag update masks
    output logic    sign_upd,
    output logic    carry_upd
);

    localparam int POS_W = $clog2(`CORE_WORD_W + 1);

    word_t                 mask;      // Active width mask
    logic [POS_W-1:0]      top_pos;   // Sign bit position
    logic [POS_W-1:0]      carry_pos; // Carry bit position
    logic [`CORE_WORD_W:0] ext;       // Result with carry bit
    word_t                 res1_c, res2_c;
    logic                  wr1_c, wr2_c;
    logic                  zero_c, sign_c, carry_c;
    logic                  zero_u, sign_u, carry_u;

    always_comb begin
        mask      = half_mode ? HALF_MASK : '1;
        top_pos   = half_mode ? POS_W'(`CORE_HALF_W - 1) : POS_W'(`CORE_WORD_W - 1);
        carry_pos = half_mode ? POS_W'(`CORE_HALF_W) : POS_W'(`CORE_WORD_W);
        ext       = '0;
        res1_c    = '0;
        res2_c    = '0;
        wr1_c     = 1'b0;
        wr2_c     = 1'b0;
        zero_c    = 1'b0;
        sign_c    = 1'b0;
        carry_c   = 1'b0;
        zero_u    = 1'b0;
        sign_u    = 1'b0;
        carry_u   = 1'b0;
        case (op)
            OP_NOT:   res1_c = ~operand_a & mask;
            OP_AND:   res1_c = operand_a & operand_b;
            OP_OR:    res1_c = operand_a | operand_b;
            OP_XOR:   res1_c = operand_a ^ operand_b;
            OP_SHFTR: begin
                res1_c  = operand_a >> 1;
                carry_c = operand_a[0];              // Bit shifted out
                carry_u = 1'b1;
            end
            OP_ROTR:  res1_c = (operand_a >> 1) | (word_t'(operand_a[0]) << top_pos);
            OP_ROTL:  res1_c = ((operand_a << 1) | word_t'(operand_a[top_pos])) & mask;
            OP_SWAP: begin
                res1_c = operand_b;
                res2_c = operand_a;
                wr2_c  = 1'b1;
            end
            OP_SHFTL, OP_INC, OP_DEC, OP_ADD, OP_SUB: begin
                case (op)
                    OP_SHFTL: ext = {1'b0, operand_a} << 1;
                    OP_INC:   ext = {1'b0, operand_a} + 1'b1;
                    OP_DEC:   ext = {1'b0, operand_a} - 1'b1;
                    OP_ADD:   ext = {1'b0, operand_a} + {1'b0, operand_b};
                    default:  ext = {1'b0, operand_a} - {1'b0, operand_b};
                endcase
                res1_c  = ext[`CORE_WORD_W-1:0] & mask;
                carry_c = ext[carry_pos];            // Carry out or borrow
                carry_u = 1'b1;
            end
            OP_EQ: begin
                zero_c = (operand_a == operand_b);
                zero_u = 1'b1;
            end
            OP_GT: begin
                sign_c = (operand_a > operand_b);    // Unsigned compare
                sign_u = 1'b1;
            end
            OP_LT: begin
                sign_c = (operand_a < operand_b);
                sign_u = 1'b1;
            end
            default: ;                               // NOP and TRAP
        endcase
        case (op)
            OP_NOT, OP_AND, OP_OR, OP_XOR, OP_SHFTR, OP_SHFTL, OP_ROTR, OP_ROTL,
            OP_INC, OP_DEC, OP_ADD, OP_SUB: begin
                wr1_c  = 1'b1;
                zero_c = (res1_c == '0);
                sign_c = res1_c[top_pos];
                zero_u = 1'b1;
                sign_u = 1'b1;
            end
            OP_SWAP: wr1_c = 1'b1;                   // Flags untouched
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr1       <= 1'b0;
            wr2       <= 1'b0;
            zero_upd  <= 1'b0;
            sign_upd  <= 1'b0;
            carry_upd <= 1'b0;
        end else if (execute_enable) begin
            wr1       <= wr1_c;
            wr2       <= wr2_c;
            zero_upd  <= zero_u;
            sign_upd  <= sign_u;
            carry_upd <= carry_u;
        end
    end

    always_ff @(posedge clk) begin
        if (execute_enable) begin
            result1   <= res1_c;
            result2   <= res2_c;
            zero_val  <= zero_c;
            sign_val  <= sign_c;
            carry_val <= carry_c;
        end
    end

endmodule

`default_nettype wire

//--- design/write_back.sv
//******************************
// Write-back stage
// Commits results and owns the status flags
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module write_back import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      write_back_enable,
    input  reg_addr_t dst1,
    input  reg_addr_t dst2,
    input  word_t     result1,
    input  word_t     result2,
    input  logic      wr1,
    input  logic      wr2,
    input  logic      zero_val,
    input  logic      sign_val,
    input  logic      carry_val,
    input  logic      zero_upd,
    input  logic      sign_upd,
    input  logic      carry_upd,
    output logic      wr1_en,     // Strobes toward reg file
    output logic      wr2_en,
    output reg_addr_t wr1_addr,
    output reg_addr_t wr2_addr,
    output word_t     wr1_data,
    output word_t     wr2_data,
    output logic      zero_flag,
    output logic      sign_flag,
    output logic      carry_flag
);

    assign wr1_en   = write_back_enable && wr1; // Only in the write-back phase
    assign wr2_en   = write_back_enable && wr2;
    assign wr1_addr = dst1;
    assign wr2_addr = dst2;
    assign wr1_data = result1;
    assign wr2_data = result2;

    always_ff @(posedge clk) begin
        if (reset) begin
            zero_flag  <= 1'b0;
            sign_flag  <= 1'b0;
            carry_flag <= 1'b0;
        end else if (write_back_enable) begin
            if (zero_upd)  zero_flag  <= zero_val;  // Masked per flag
            if (sign_upd)  sign_flag  <= sign_val;
            if (carry_upd) carry_flag <= carry_val;
        end
    end

endmodule

`default_nettype wire

//--- design/core_top.sv
//******************************
// Core top
// Four-phase 20-bit processor core
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module core_top import core_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CORE_WORD_W-1:0] instruction,
    input  logic                    load_en,
    input  reg_addr_t               load_addr,
    input  reg_addr_t               rd_addr,
    input  word_t                   load_data,
    output word_t                   rd_data,
    output logic                    fetch_enable,
    output logic                    decode_enable,
    output logic                    execute_enable,
    output logic                    write_back_enable,
    output logic                    trap_mode,
    output logic                    zero_flag,
    output logic                    sign_flag,
    output logic                    carry_flag
);

    opcode_e   op;
    reg_addr_t src1, src2, dst1, dst2;
    logic      half_mode;
    word_t     rd_a_data, rd_b_data, operand_a, operand_b;
    word_t     result1, result2, wr1_data, wr2_data;
    logic      wr1, wr2, wr1_en, wr2_en;
    reg_addr_t wr1_addr, wr2_addr;
    logic      zero_val, sign_val, carry_val, zero_upd, sign_upd, carry_upd;

    phase_sequencer i_seq (.clk, .reset, .op, .fetch_enable, .decode_enable,
        .execute_enable, .write_back_enable, .trap_mode);

    instr_decode i_dec (.clk, .reset, .fetch_enable, .decode_enable, .instruction,
        .rd_a_data, .rd_b_data, .op, .src1, .src2, .dst1, .dst2, .half_mode,
        .operand_a, .operand_b);

    reg_file i_regs (.clk, .reset, .rd_a_addr(src1), .rd_b_addr(src2), .rd_addr,
        .rd_a_data, .rd_b_data, .rd_data, .wr1_en, .wr2_en, .wr1_addr, .wr2_addr,
        .wr1_data, .wr2_data, .load_en, .load_addr, .load_data);

    alu_execute i_alu (.clk, .reset, .execute_enable, .op, .half_mode, .operand_a,
        .operand_b, .result1, .result2, .wr1, .wr2, .zero_val, .sign_val, .carry_val,
        .zero_upd, .sign_upd, .carry_upd);

    write_back i_wb (.clk, .reset, .write_back_enable, .dst1, .dst2, .result1, .result2,
        .wr1, .wr2, .zero_val, .sign_val, .carry_val, .zero_upd, .sign_upd, .carry_upd,
        .wr1_en, .wr2_en, .wr1_addr, .wr2_addr, .wr1_data, .wr2_data,
        .zero_flag, .sign_flag, .carry_flag);

endmodule

`default_nettype wire

//--- verif/core_tb.sv
//******************************
// Core testbench
// Reference model and assertion checks for the four-phase core
//******************************
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module core_tb import core_pkg::*; ();

    localparam int CLK_NS     = 8;
    localparam int N_FULL     = 24;                                // Full-word instructions
    localparam int N_HALF     = 24;                                // Half-word instructions
    localparam int N_CMP      = 16;                                // Swap and compare instructions
    localparam int N_STEPS    = 8 + 3 * (N_FULL + N_HALF + N_CMP) + 8; // Loads, instructions, idle
    localparam int TIMEOUT_NS = (N_STEPS * 4 + 50) * CLK_NS;

    logic                    clk, reset, load_en;
    logic [`CORE_WORD_W-1:0] instruction;
    reg_addr_t               load_addr, rd_addr;
    word_t                   load_data, rd_data;
    logic                    fetch_enable, decode_enable, execute_enable, write_back_enable;
    logic                    trap_mode, zero_flag, sign_flag, carry_flag;

    integer seed;
    int     errors;
    string  test_name;

    // Reference model state
    word_t                   m_regs [`CORE_NUM_REGS];
    logic                    m_zero, m_sign, m_carry, m_trap;
    logic [1:0]              m_phase;                              // 0 fetch .. 3 write-back
    logic [`CORE_WORD_W-1:0] m_instr;                              // Instruction in flight
    word_t                   exp_rd;
    logic [3:0]              exp_en;

    opcode_e logic_ops [8] = '{OP_NOT, OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB, OP_INC, OP_DEC};
    opcode_e shift_ops [4] = '{OP_SHFTR, OP_SHFTL, OP_ROTR, OP_ROTL};
    opcode_e cmp_ops [4]   = '{OP_SWAP, OP_EQ, OP_GT, OP_LT};

    core_top i_dut (.clk, .reset, .instruction, .load_en, .load_addr, .rd_addr, .load_data,
        .rd_data, .fetch_enable, .decode_enable, .execute_enable, .write_back_enable,
        .trap_mode, .zero_flag, .sign_flag, .carry_flag);

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) rd_addr <= rd_addr + 3'd1;              // Sweep all registers

    // Applies one committed instruction to the model
    task automatic apply_model(input logic [`CORE_WORD_W-1:0] ins);
        logic [5:0]  code;
        int          w;
        logic [20:0] mask, a, b, r;
        logic        c, res_op, has_c;
        word_t       res;
        code   = ins[19:14];
        w      = ins[`CORE_MODE_BIT] ? `CORE_HALF_W : `CORE_WORD_W;
        mask   = (21'd1 << w) - 21'd1;
        a      = {1'b0, m_regs[ins[13:11]]} & mask;
        b      = {1'b0, m_regs[ins[10:8]]} & mask;
        r      = '0;
        c      = 1'b0;
        res_op = 1'b1;
        has_c  = 1'b0;
        case (code)
            OP_NOT:   r = ~a;
            OP_AND:   r = a & b;
            OP_OR:    r = a | b;
            OP_XOR:   r = a ^ b;
            OP_SHFTR: begin r = a >> 1; c = a[0]; has_c = 1'b1; end
            OP_SHFTL: begin r = a << 1; c = a[w-1]; has_c = 1'b1; end
            OP_ROTR:  r = (a >> 1) | (21'(a[0]) << (w - 1));
            OP_ROTL:  r = (a << 1) | 21'(a[w-1]);
            OP_INC:   begin r = a + 21'd1; c = r[w]; has_c = 1'b1; end
            OP_DEC:   begin r = a - 21'd1; c = r[w]; has_c = 1'b1; end // Borrow
            OP_ADD:   begin r = a + b; c = r[w]; has_c = 1'b1; end
            OP_SUB:   begin r = a - b; c = r[w]; has_c = 1'b1; end
            OP_SWAP: begin
                res_op = 1'b0;
                m_regs[ins[7:5]] <= b[19:0];
                m_regs[ins[4:2]] <= a[19:0];                       // Later write wins
            end
            OP_EQ:    begin res_op = 1'b0; m_zero <= (a == b); end
            OP_GT:    begin res_op = 1'b0; m_sign <= (a > b); end
            OP_LT:    begin res_op = 1'b0; m_sign <= (a < b); end
            default:  res_op = 1'b0;                               // NOP, TRAP
        endcase
        if (res_op) begin
            res = r[19:0] & mask[19:0];
            m_regs[ins[7:5]] <= res;
            m_zero <= (res == '0);
            m_sign <= res[w-1];
            if (has_c) m_carry <= c;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) m_regs[i] <= '0;
            m_phase <= 2'd0;
            m_trap  <= 1'b0;
            m_zero  <= 1'b0;
            m_sign  <= 1'b0;
            m_carry <= 1'b0;
            m_instr <= '0;
        end else begin
            if (!m_trap) begin
                m_phase <= m_phase + 2'd1;
                if (m_phase == 2'd0) m_instr <= instruction;
                if (m_phase == 2'd1 && m_instr[19:14] == OP_TRAP) m_trap <= 1'b1;
                if (m_phase == 2'd3) apply_model(m_instr);
            end
            if (load_en && !(m_phase == 2'd3 && !m_trap)) m_regs[load_addr] <= load_data;
        end
    end

    assign exp_rd = m_regs[rd_addr];
    assign exp_en = m_trap ? 4'b0000 : (4'b1000 >> m_phase);   // One enable per phase

    task automatic report(input string check, input word_t expected, input word_t actual);
        errors++;
        $display("CHECK FAILED %s/%s: expected %h, actual %h", test_name, check, expected, actual);
    endtask

    a_enables: assert property (@(posedge clk) disable iff (reset)
        {fetch_enable, decode_enable, execute_enable, write_back_enable} == exp_en)
        else report("enables", word_t'($sampled(exp_en)), word_t'($sampled({fetch_enable,
            decode_enable, execute_enable, write_back_enable})));
    a_trap: assert property (@(posedge clk) disable iff (reset) trap_mode == m_trap)
        else report("trap_mode", word_t'($sampled(m_trap)), word_t'($sampled(trap_mode)));
    a_rd_data: assert property (@(posedge clk) disable iff (reset) rd_data == exp_rd)
        else report("rd_data", $sampled(exp_rd), $sampled(rd_data));
    a_flags: assert property (@(posedge clk) disable iff (reset)
        {zero_flag, sign_flag, carry_flag} == {m_zero, m_sign, m_carry})
        else report("flags", word_t'($sampled({m_zero, m_sign, m_carry})),
            word_t'($sampled({zero_flag, sign_flag, carry_flag})));

    function automatic logic [31:0] rand_bits();
        rand_bits = $random(seed);
    endfunction

    // Zero and all ones show up often to reach carry and zero
    function automatic word_t rand_word();
        logic [31:0] r;
        r = rand_bits();
        case (r[31:29])
            3'd0:    rand_word = '0;
            3'd1:    rand_word = '1;
            default: rand_word = r[19:0];
        endcase
    endfunction

    function automatic logic [`CORE_WORD_W-1:0] encode(input opcode_e op, input reg_addr_t s1,
        input reg_addr_t s2, input reg_addr_t d1, input reg_addr_t d2, input logic half);
        encode = {op, s1, s2, d1, d2, half, 1'b0};
    endfunction

    task automatic load_reg(input reg_addr_t addr, input word_t data);
        while (execute_enable) @(posedge clk);                     // Next edge is write-back
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
        @(posedge clk);
        load_en   <= 1'b0;
    endtask

    // Holds the instruction until fetched, then waits for commit or trap
    task automatic issue(input logic [`CORE_WORD_W-1:0] ins);
        instruction <= ins;
        @(posedge clk);
        while (!fetch_enable) @(posedge clk);
        instruction <= {OP_NOP, 14'd0};
        @(posedge clk);
        if (ins[19:14] == OP_TRAP) begin
            while (!trap_mode) @(posedge clk);
        end else begin
            while (!write_back_enable) @(posedge clk);
        end
    endtask

    task automatic run_group(input int group, input int count, input int half_sel);
        logic [31:0] r;
        opcode_e     op;
        logic        half;
        for (int n = 0; n < count; n++) begin
            r = rand_bits();
            load_reg(r[2:0], rand_word());                         // Fresh operand each time
            case (group)
                0:       op = logic_ops[r[5:3]];
                1:       op = r[8] ? shift_ops[r[7:6]] : logic_ops[r[5:3]];
                default: op = cmp_ops[r[7:6]];
            endcase
            half = (half_sel == 2) ? r[9] : (half_sel == 1);
            issue(encode(op, r[12:10], r[15:13], r[18:16], r[21:19], half));
        end
    endtask

    initial begin
        seed        = 32'he0f63aaf;
        errors      = 0;
        test_name   = "reset";
        clk         = 1'b0;
        reset       = 1'b1;
        instruction = {OP_NOP, 14'd0};
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        rd_addr     = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (8) @(posedge clk);                                 // Idle phase rotation
        test_name = "load";
        for (int i = 0; i < `CORE_NUM_REGS; i++) load_reg(reg_addr_t'(i), rand_word());
        test_name = "full_word";
        run_group(0, N_FULL, 0);
        test_name = "half_word";
        run_group(1, N_HALF, 1);
        test_name = "swap_compare";
        run_group(2, N_CMP, 2);
        test_name = "trap";
        issue(encode(OP_TRAP, 3'd0, 3'd0, 3'd0, 3'd0, 1'b0));
        repeat (12) @(posedge clk);                                // Core must stay halted
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/core_pkg.sv
design/phase_sequencer.sv
design/instr_decode.sv
design/reg_file.sv
design/alu_execute.sv
design/write_back.sv
design/core_top.sv
verif/core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
